/* design/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath sizes.
`define RV_XLEN   32
`define RV_NREG   16
`define RV_RIDX_W 4

// major opcodes.
`define RV_OP_LUI   7'b0110111
`define RV_OP_AUIPC 7'b0010111
`define RV_OP_JAL   7'b1101111
`define RV_OP_IMM   7'b0010011
`define RV_OP_REG   7'b0110011

`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101  // srl and sra, split on funct7 bit 5.
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

`endif

/* design/rv_pkg.sv */
`include "rv_defines.svh"

package rv_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS  // lui, forwards op2.
  } alu_op_e;

  typedef enum logic [1:0] {SRC1_REG, SRC1_PC, SRC1_ZERO} src1_sel_e;

  typedef enum logic [1:0] {SRC2_REG, SRC2_IMM, SRC2_FOUR} src2_sel_e;

  typedef struct packed {
    alu_op_e               alu_op;
    logic [`RV_RIDX_W-1:0] rs1;
    logic [`RV_RIDX_W-1:0] rs2;
    logic [`RV_RIDX_W-1:0] rd;
    logic                  use_rs1;
    logic                  use_rs2;
    src1_sel_e             src1_sel;
    src2_sel_e             src2_sel;
    logic [`RV_XLEN-1:0]   imm;
  } dec_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   op1;
    logic [`RV_XLEN-1:0]   op2;
    alu_op_e               alu_op;
    logic [`RV_RIDX_W-1:0] rd;
  } issue_t;

  typedef struct packed {
    logic [`RV_RIDX_W-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
  } wb_t;

endpackage

/* design/rv_decoder.sv */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_decoder (
  input  logic [31:0]  inst_i,
  output rv_pkg::dec_t dec_o
);
  import rv_pkg::*;

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic                alt;  // funct7 bit 5.
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_sh;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign alt    = inst_i[30];
  assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u  = {inst_i[31:12], 12'b0};
  assign imm_sh = {27'b0, inst_i[24:20]};  // shamt only.

  // funct3 to alu op, sub only legal for register form.
  function automatic alu_op_e f3_op(input logic [2:0] f3, input logic sub, input logic arith);
    alu_op_e op;
    case (f3)
      `RV_F3_ADD:  op = sub ? ALU_SUB : ALU_ADD;
      `RV_F3_SLL:  op = ALU_SLL;
      `RV_F3_SLT:  op = ALU_SLT;
      `RV_F3_SLTU: op = ALU_SLTU;
      `RV_F3_XOR:  op = ALU_XOR;
      `RV_F3_SR:   op = arith ? ALU_SRA : ALU_SRL;
      `RV_F3_OR:   op = ALU_OR;
      default:     op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    // default is addi rd, x0, 0.
    dec_o.alu_op   = ALU_ADD;
    dec_o.rs1      = inst_i[18:15];
    dec_o.rs2      = inst_i[23:20];
    dec_o.rd       = inst_i[10:7];
    dec_o.use_rs1  = 1'b0;
    dec_o.use_rs2  = 1'b0;
    dec_o.src1_sel = SRC1_ZERO;
    dec_o.src2_sel = SRC2_IMM;
    dec_o.imm      = '0;
    case (opcode)
      `RV_OP_LUI: begin
        dec_o.alu_op = ALU_PASS;
        dec_o.imm    = imm_u;
      end
      `RV_OP_AUIPC: begin
        dec_o.src1_sel = SRC1_PC;
        dec_o.imm      = imm_u;
      end
      `RV_OP_JAL: begin
        dec_o.src1_sel = SRC1_PC;  // link value only.
        dec_o.src2_sel = SRC2_FOUR;
      end
      `RV_OP_IMM: begin
        dec_o.alu_op   = f3_op(funct3, 1'b0, alt);
        dec_o.use_rs1  = 1'b1;
        dec_o.src1_sel = SRC1_REG;
        dec_o.imm      = (funct3 == `RV_F3_SLL || funct3 == `RV_F3_SR) ? imm_sh : imm_i;
      end
      `RV_OP_REG: begin
        dec_o.alu_op   = f3_op(funct3, alt, alt);
        dec_o.use_rs1  = 1'b1;
        dec_o.use_rs2  = 1'b1;
        dec_o.src1_sel = SRC1_REG;
        dec_o.src2_sel = SRC2_REG;
      end
      default: ;
    endcase
  end

endmodule

/* design/rv_idu.sv */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_idu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [31:0]           inst_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output logic [`RV_RIDX_W-1:0] rs1_o,
  output logic [`RV_RIDX_W-1:0] rs2_o,
  input  logic [`RV_XLEN-1:0]   rdata1_i,
  input  logic [`RV_XLEN-1:0]   rdata2_i,
  input  logic [`RV_NREG-1:0]   busy_i,
  input  logic                  wb_valid_i,
  input  rv_pkg::wb_t           wb_i,
  output logic                  iss_valid_o,
  output rv_pkg::issue_t        iss_o,
  input  logic                  exu_ready_i,
  output logic                  set_busy_o,
  output logic [`RV_RIDX_W-1:0] set_rd_o
);
  import rv_pkg::*;

  typedef enum logic {S_EMPTY, S_HELD} state_e;

  state_e              state_q;
  logic [31:0]         inst_q;
  logic [`RV_XLEN-1:0] pc_q;
  dec_t                dec;
  logic                byp1, byp2;
  logic                hazard;
  logic                issue;
  logic [`RV_XLEN-1:0] val1, val2;
  logic                reads_rs1, reads_rs2;

  rv_decoder u_dec (
    .inst_i (inst_q),
    .dec_o  (dec)
  );

  assign rs1_o = dec.rs1;
  assign rs2_o = dec.rs2;

  // ----------------------------------------
  // hazard and bypass
  // ----------------------------------------
  assign byp1 = wb_valid_i && wb_i.rd == dec.rs1 && dec.rs1 != '0;
  assign byp2 = wb_valid_i && wb_i.rd == dec.rs2 && dec.rs2 != '0;
  assign val1 = byp1 ? wb_i.data : rdata1_i;
  assign val2 = byp2 ? wb_i.data : rdata2_i;

  assign hazard = (dec.use_rs1 && busy_i[dec.rs1] && !byp1) ||
                  (dec.use_rs2 && busy_i[dec.rs2] && !byp2);

  assign iss_valid_o = state_q == S_HELD && !hazard;
  assign issue       = iss_valid_o && exu_ready_i;
  assign ready_o     = state_q == S_EMPTY || issue;  // refill while issuing.
  assign set_busy_o  = issue && dec.rd != '0;
  assign set_rd_o    = dec.rd;

  always_comb begin
    case (dec.src1_sel)
      SRC1_REG: iss_o.op1 = val1;
      SRC1_PC:  iss_o.op1 = pc_q;
      default:  iss_o.op1 = '0;
    endcase
    case (dec.src2_sel)
      SRC2_REG: iss_o.op2 = val2;
      SRC2_IMM: iss_o.op2 = dec.imm;
      default:  iss_o.op2 = `RV_XLEN'd4;
    endcase
    iss_o.alu_op = dec.alu_op;
    iss_o.rd     = dec.rd;
  end

  // ----------------------------------------
  // capture
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_EMPTY;
    end else if (valid_i && ready_o) begin
      state_q <= S_HELD;
    end else if (issue) begin
      state_q <= S_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  // sources read by the held opcode, taken from the raw bits.
  assign reads_rs1 = inst_q[6:0] == `RV_OP_IMM || inst_q[6:0] == `RV_OP_REG;
  assign reads_rs2 = inst_q[6:0] == `RV_OP_REG;

  // regfile busy state must agree with the issue decision.
  a_no_busy_issue: assert property (@(posedge clk) disable iff (rst)
    iss_valid_o |->
      (!reads_rs1 || !busy_i[inst_q[18:15]] || (wb_valid_i && wb_i.rd == inst_q[18:15])) &&
      (!reads_rs2 || !busy_i[inst_q[23:20]] || (wb_valid_i && wb_i.rd == inst_q[23:20])))
    else $error("issue with an unresolved source");

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_RIDX_W-1:0] rs1_i,
  input  logic [`RV_RIDX_W-1:0] rs2_i,
  output logic [`RV_XLEN-1:0]   rdata1_o,
  output logic [`RV_XLEN-1:0]   rdata2_o,
  input  logic                  wb_valid_i,
  input  rv_pkg::wb_t           wb_i,
  input  logic                  set_busy_i,
  input  logic [`RV_RIDX_W-1:0] set_rd_i,
  output logic [`RV_NREG-1:0]   busy_o
);

  logic [`RV_XLEN-1:0] regs [`RV_NREG];
  logic [`RV_NREG-1:0] busy_q;

  always_ff @(posedge clk) begin
    if (wb_valid_i && wb_i.rd != '0) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];  // x0 reads zero.
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  // scoreboard.
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      if (wb_valid_i) busy_q[wb_i.rd] <= 1'b0;
      if (set_busy_i) busy_q[set_rd_i] <= 1'b1;  // set wins on a tie.
    end
  end

  assign busy_o = busy_q;

  a_wb_was_busy: assert property (@(posedge clk) disable iff (rst)
    wb_valid_i && wb_i.rd != '0 |-> busy_q[wb_i.rd])
    else $error("writeback to register x%0d not marked busy", wb_i.rd);

endmodule

/* design/rv_exu.sv */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_exu (
  input  logic           clk,
  input  logic           rst,
  input  logic           iss_valid_i,
  input  rv_pkg::issue_t iss_i,
  output logic           ready_o,
  output logic           wb_valid_o,
  output rv_pkg::wb_t    wb_o
);
  import rv_pkg::*;

  logic                  busy_q;  // an op is held.
  logic [4:0]            cnt_q;   // shift steps left.
  alu_op_e               alu_q;
  logic [`RV_RIDX_W-1:0] rd_q;
  logic [`RV_XLEN-1:0]   a_q, b_q;
  logic [`RV_XLEN-1:0]   res;
  logic                  take;
  logic                  is_shift;

  assign ready_o  = cnt_q == '0;
  assign take     = iss_valid_i && ready_o;
  assign is_shift = iss_i.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA};

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (take) begin
      busy_q <= 1'b1;
      cnt_q  <= is_shift ? iss_i.op2[4:0] : 5'd0;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 5'd1;
    end else begin
      busy_q <= 1'b0;
    end
  end

  // operands, a_q doubles as the shift register.
  always_ff @(posedge clk) begin
    if (take) begin
      alu_q <= iss_i.alu_op;
      rd_q  <= iss_i.rd;
      a_q   <= iss_i.op1;
      b_q   <= iss_i.op2;
    end else if (cnt_q != '0) begin
      case (alu_q)
        ALU_SLL: a_q <= {a_q[`RV_XLEN-2:0], 1'b0};
        ALU_SRL: a_q <= {1'b0, a_q[`RV_XLEN-1:1]};
        default: a_q <= {a_q[`RV_XLEN-1], a_q[`RV_XLEN-1:1]};  // sra.
      endcase
    end
  end

  always_comb begin
    case (alu_q)
      ALU_ADD:  res = a_q + b_q;
      ALU_SUB:  res = a_q - b_q;
      ALU_AND:  res = a_q & b_q;
      ALU_OR:   res = a_q | b_q;
      ALU_XOR:  res = a_q ^ b_q;
      ALU_SLT:  res = {{(`RV_XLEN-1){1'b0}}, $signed(a_q) < $signed(b_q)};
      ALU_SLTU: res = {{(`RV_XLEN-1){1'b0}}, a_q < b_q};
      ALU_PASS: res = b_q;
      default:  res = a_q;  // shift result already in place.
    endcase
  end

  assign wb_valid_o = busy_q && cnt_q == '0;
  assign wb_o.rd    = rd_q;
  assign wb_o.data  = res;

  // an issue offered during a shift waits unchanged.
  a_shift_hold: assert property (@(posedge clk) disable iff (rst)
    cnt_q != '0 && iss_valid_i |=> iss_valid_i && $stable(iss_i))
    else $error("issue changed or dropped during a shift");

endmodule

/* design/rv_core_top.sv */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_core_top (
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         inst_i,
  input  logic [`RV_XLEN-1:0] pc_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  output logic                wb_valid_o,
  output rv_pkg::wb_t         wb_o
);
  import rv_pkg::*;

  logic [`RV_RIDX_W-1:0] rs1, rs2, set_rd;
  logic [`RV_XLEN-1:0]   rdata1, rdata2;
  logic [`RV_NREG-1:0]   busy;
  logic                  set_busy;
  logic                  iss_valid, exu_ready;
  issue_t                iss;

  rv_idu u_idu (
    .clk, .rst, .inst_i, .pc_i,
    .valid_i     (in_valid_i),
    .ready_o     (in_ready_o),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rdata1_i    (rdata1),
    .rdata2_i    (rdata2),
    .busy_i      (busy),
    .wb_valid_i  (wb_valid_o),
    .wb_i        (wb_o),
    .iss_valid_o (iss_valid),
    .iss_o       (iss),
    .exu_ready_i (exu_ready),
    .set_busy_o  (set_busy),
    .set_rd_o    (set_rd)
  );

  rv_regfile u_rf (
    .clk, .rst,
    .rs1_i (rs1), .rs2_i (rs2), .rdata1_o (rdata1), .rdata2_o (rdata2),
    .wb_valid_i (wb_valid_o), .wb_i (wb_o),
    .set_busy_i (set_busy), .set_rd_i (set_rd), .busy_o (busy)
  );

  rv_exu u_exu (
    .clk, .rst,
    .iss_valid_i (iss_valid), .iss_i (iss), .ready_o (exu_ready),
    .wb_valid_o, .wb_o
  );

endmodule

/* test/tb_core.sv */
`timescale 1ns/100ps
`include "rv_defines.svh"

module tb_core;
  import rv_pkg::*;

  localparam int          NUM_INST      = 300;
  localparam int          READY_TIMEOUT = 200;  // cycles, longest shift plus margin.
  localparam int          DRAIN_TIMEOUT = 2000;
  localparam logic [31:0] BASE_PC       = 32'h0000_1000;

  typedef logic [31:0] regs_t [16];

  logic        clk;
  logic        rst;
  logic [31:0] inst_i;
  logic [31:0] pc_i;
  logic        in_valid_i;
  logic        in_ready_o;
  logic        wb_valid_o;
  wb_t         wb_o;

  integer      seed = 83;
  logic [31:0] prog [NUM_INST];
  wb_t         exp_q [$];
  wb_t         head;
  int          beats = 0;

  rv_core_top uut (
    .clk, .rst, .inst_i, .pc_i, .in_valid_i, .in_ready_o, .wb_valid_o, .wb_o
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------
  // program generation and reference
  // ----------------------------------------
  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // x0 to x3 most of the time, so results feed each other.
  function automatic logic [3:0] pick_reg();
    logic [3:0] r;
    r = (rand_below(8) < 6) ? 4'(rand_below(4)) : 4'(rand_below(16));
    return r;
  endfunction

  function automatic logic [31:0] gen_inst();
    logic [3:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [31:0] r;
    logic [31:0] inst;
    int          kind;
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    f3   = 3'(rand_below(8));
    imm  = 12'(rand_below(4096));
    r    = $random(seed);
    kind = rand_below(10);
    f7   = ((f3 == `RV_F3_SR || (f3 == `RV_F3_ADD && kind >= 6)) && r[31]) ? 7'b0100000 : 7'b0;
    case (kind)
      0: inst = {r[19:0], 1'b0, rd, `RV_OP_LUI};
      1: inst = {r[19:0], 1'b0, rd, `RV_OP_AUIPC};
      2: inst = {r[19:0], 1'b0, rd, `RV_OP_JAL};
      3, 4, 5: begin
        if (f3 == `RV_F3_SLL || f3 == `RV_F3_SR) imm = {f7, r[24:20]};  // shamt form.
        inst = {imm, 1'b0, rs1, f3, 1'b0, rd, `RV_OP_IMM};
      end
      default: inst = {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, `RV_OP_REG};
    endcase
    return inst;
  endfunction

  function automatic wb_t ref_result(input logic [31:0] inst, input logic [31:0] pc,
                                     input regs_t rf);
    logic [31:0] a, b, res;
    logic        is_reg;
    wb_t         w;
    is_reg = inst[6:0] == `RV_OP_REG;
    a      = rf[inst[18:15]];
    b      = is_reg ? rf[inst[23:20]] : {{20{inst[31]}}, inst[31:20]};
    case (inst[14:12])
      `RV_F3_ADD:  res = (is_reg && inst[30]) ? a - b : a + b;
      `RV_F3_SLL:  res = a << b[4:0];
      `RV_F3_SLT:  res = {31'b0, $signed(a) < $signed(b)};
      `RV_F3_SLTU: res = {31'b0, a < b};
      `RV_F3_XOR:  res = a ^ b;
      `RV_F3_SR:   res = inst[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      `RV_F3_OR:   res = a | b;
      default:     res = a & b;
    endcase
    if (inst[6:0] == `RV_OP_LUI) res = {inst[31:12], 12'b0};
    if (inst[6:0] == `RV_OP_AUIPC) res = pc + {inst[31:12], 12'b0};
    if (inst[6:0] == `RV_OP_JAL) res = pc + 32'd4;  // link only.
    w.rd   = inst[10:7];
    w.data = res;
    return w;
  endfunction

  task automatic build_program();
    regs_t       model;
    wb_t         w;
    logic [31:0] pc;
    foreach (model[i]) model[i] = '0;
    for (int i = 0; i < NUM_INST; i++) begin
      if (i < 15) begin
        prog[i] = {12'(rand_below(4096)), 5'd0, `RV_F3_ADD, 1'b0, 4'(i + 1), `RV_OP_IMM};
      end else begin
        prog[i] = gen_inst();
      end
      pc = BASE_PC + 32'(4 * i);
      w  = ref_result(prog[i], pc, model);
      if (w.rd != '0) model[w.rd] = w.data;  // x0 stays zero.
      exp_q.push_back(w);
    end
  endtask

  // ----------------------------------------
  // checking
  // ----------------------------------------
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  always @(negedge clk) begin
    if (!rst && wb_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("writeback beat at %0t with no instruction outstanding", $time);
        $display("Finished with errors");
        $fatal(1, "extra writeback");
      end else begin
        head = exp_q.pop_front();
        check_value($sformatf("beat %0d rd", beats), 32'(wb_o.rd), 32'(head.rd));
        check_value($sformatf("beat %0d data", beats), wb_o.data, head.data);
        beats++;
      end
    end
  end

  task automatic send_inst(input logic [31:0] inst, input logic [31:0] pc);
    int waited;
    in_valid_i <= 1'b1;
    inst_i     <= inst;
    pc_i       <= pc;
    waited = 0;
    @(negedge clk);
    while (!in_ready_o && waited < READY_TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (!in_ready_o) begin
      $display("in_ready_o stayed low for %0d cycles at pc %h", READY_TIMEOUT, pc);
      $display("Finished with errors");
      $fatal(1, "handshake timeout");
    end else begin
      @(posedge clk);  // accepted on this edge.
    end
  endtask

  initial begin
    int gap;
    int waited;
    rst        <= 1'b1;
    in_valid_i <= 1'b0;
    inst_i     <= '0;
    pc_i       <= '0;
    build_program();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("in_ready_o after reset", 32'(in_ready_o), 32'd1);
    check_value("wb_valid_o after reset", 32'(wb_valid_o), 32'd0);
    @(posedge clk);
    for (int i = 0; i < NUM_INST; i++) begin
      gap = (rand_below(4) == 0) ? 1 + rand_below(3) : 0;
      repeat (gap) begin
        in_valid_i <= 1'b0;
        @(posedge clk);
      end
      send_inst(prog[i], BASE_PC + 32'(4 * i));
    end
    in_valid_i <= 1'b0;
    waited = 0;
    while (beats < NUM_INST && waited < DRAIN_TIMEOUT) begin
      waited++;
      @(posedge clk);
    end
    if (beats < NUM_INST) begin
      $display("timed out waiting for writeback, %0d of %0d retired", beats, NUM_INST);
      $display("Finished with errors");
      $fatal(1, "drain timeout");
    end else begin
      repeat (40) @(posedge clk);  // room for a stray late beat.
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

/* all.f */
+incdir+design
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_idu.sv
design/rv_regfile.sv
design/rv_exu.sv
design/rv_core_top.sv
test/tb_core.sv

/* Makefile */
# Verilator simulation of the RV32E decode and execute slice.

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the binary's exit status carries pass or fail.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
